/* source/host_bus_pkg.sv */
package host_bus_pkg;

    // MMIO bus
    localparam int mmio_data_w = 64;
    localparam int mmio_addr_w = 32;

    // DMA bus
    localparam int host_addr_w = 64;
    localparam int dma_size_w = 43;
    localparam int beat_w = 512;

    // Input regions
    localparam int word_w = 32;
    localparam int words_per_beat = 16;
    localparam int region_count = 3;

    // MMIO write address fields
    localparam int ack_bit = 0;
    localparam int req_bit = 31;
    localparam int size_lsb = 1;
    localparam int size_msb = 30;

    // Status word with its code in the low byte
    localparam int status_code_w = 8;
    localparam logic [status_code_w-1:0] status_idle = 8'd0;
    localparam logic [status_code_w-1:0] status_batch_done = 8'd1;
    localparam logic [status_code_w-1:0] status_all_done = 8'd2;
    localparam int fetch_done_bit = 8;

endpackage

/* source/batch_pkg.sv */
package batch_pkg;

    // Result lanes packed into one DMA write beat
    localparam int result_w = 128;
    localparam int lanes = 4;

    // Main memory read latency in cycles
    localparam int result_wait = 4;

    // Main address is {thread, slot_offset}
    localparam int main_addr_w = 32;
    localparam int thread_field_w = 16;
    localparam logic [15:0] slot_offset = 16'hfff0;

endpackage

/* source/beat_unloader.sv */
module beat_unloader (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                start,
    input  logic [host_bus_pkg::dma_size_w-1:0] beat_count,
    input  logic                                dma_rd_empty,
    input  logic [host_bus_pkg::beat_w-1:0]     dma_rd_data,
    output logic                                dma_rd_en,
    output logic [host_bus_pkg::word_w-1:0]     word_data,
    output logic                                word_valid,
    output logic                                region_end
);

    localparam int word_cnt_w = $clog2(host_bus_pkg::words_per_beat);
    localparam logic [word_cnt_w-1:0] last_word = word_cnt_w'(host_bus_pkg::words_per_beat - 1);
    localparam logic [host_bus_pkg::dma_size_w-1:0] one_beat = 1;

    typedef enum logic [1:0] {st_idle, st_req, st_load, st_shift} state_t;

    state_t state;
    logic [host_bus_pkg::dma_size_w-1:0] beats_left;
    logic [word_cnt_w-1:0] word_cnt;
    logic [host_bus_pkg::beat_w-1:0] beat_buf;
    logic beat_end;

    assign dma_rd_en = (state == st_req) && !dma_rd_empty;
    assign word_valid = (state == st_shift);
    assign word_data = beat_buf[host_bus_pkg::word_w-1:0];
    assign beat_end = word_valid && (word_cnt == last_word);

    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n) begin
            state <= st_idle;
            beats_left <= '0;
            word_cnt <= '0;
            region_end <= 1'b0;
        end else begin
            region_end <= beat_end && (beats_left == one_beat);
            case (state)
                st_idle: begin
                    if (start) begin
                        beats_left <= beat_count;
                        state <= st_req;
                    end
                end
                // Data shows up the cycle after the read strobe
                st_req: begin
                    if (!dma_rd_empty)
                        state <= st_load;
                end
                st_load: begin
                    word_cnt <= '0;
                    state <= st_shift;
                end
                st_shift: begin
                    word_cnt <= word_cnt + 1'b1;
                    if (word_cnt == last_word) begin
                        beats_left <= beats_left - 1'b1;
                        state <= (beats_left == one_beat) ? st_idle : st_req;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    // Word 0 sits at the bottom and leaves first
    always_ff @(posedge clk) begin
        if (state == st_load)
            beat_buf <= dma_rd_data;
        else if (state == st_shift)
            beat_buf <= beat_buf >> host_bus_pkg::word_w;
    end

endmodule

/* source/descriptor_sequencer.sv */
module descriptor_sequencer (
    input  logic                                   clk,
    input  logic                                   rst_n,
    input  logic                                   mmio_wr_en,
    input  logic [host_bus_pkg::mmio_addr_w-1:0]   mmio_wr_addr,
    input  logic [host_bus_pkg::mmio_data_w-1:0]   mmio_wr_data,
    input  logic                                   dma_rd_empty,
    input  logic [host_bus_pkg::beat_w-1:0]        dma_rd_data,
    output logic                                   dma_rd_go,
    output logic                                   dma_rd_en,
    output logic [host_bus_pkg::host_addr_w-1:0]   dma_rd_addr,
    output logic [host_bus_pkg::dma_size_w-1:0]    dma_rd_size,
    output logic [host_bus_pkg::word_w-1:0]        word_data,
    output logic [host_bus_pkg::region_count-1:0]  word_we,
    output logic                                   wr_base_load,
    output logic [host_bus_pkg::host_addr_w-1:0]   wr_base,
    output logic                                   fetch_done
);

    localparam int cap_w = $clog2(host_bus_pkg::region_count + 1);
    localparam int idx_w = $clog2(host_bus_pkg::region_count);
    localparam int size_bits = host_bus_pkg::size_msb - host_bus_pkg::size_lsb + 1;
    localparam logic [cap_w-1:0] cap_base = cap_w'(host_bus_pkg::region_count);
    localparam logic [idx_w-1:0] last_region = idx_w'(host_bus_pkg::region_count - 1);

    typedef enum logic [1:0] {walk_idle, walk_check, walk_busy} walk_t;

    walk_t walk_state;
    logic [cap_w-1:0] cap_idx;
    logic [idx_w-1:0] walk_idx;
    logic desc_wr;
    logic desc_region;
    logic [host_bus_pkg::dma_size_w-1:0] size_field;
    logic [host_bus_pkg::host_addr_w-1:0] reg_addr [host_bus_pkg::region_count];
    logic [host_bus_pkg::dma_size_w-1:0] reg_size [host_bus_pkg::region_count];
    logic [host_bus_pkg::region_count-1:0] reg_req;
    logic word_valid;
    logic region_end;

    assign desc_wr = mmio_wr_en && !mmio_wr_addr[host_bus_pkg::ack_bit];
    assign desc_region = desc_wr && (cap_idx != cap_base);
    assign size_field = {{(host_bus_pkg::dma_size_w - size_bits){1'b0}},
                         mmio_wr_addr[host_bus_pkg::size_msb:host_bus_pkg::size_lsb]};

    // Fourth write and any later one carry the writeback base
    assign wr_base_load = desc_wr && (cap_idx == cap_base);
    assign wr_base = mmio_wr_data;

    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n) begin
            cap_idx <= '0;
            reg_req <= '0;
        end else if (desc_region) begin
            reg_req[cap_idx] <= mmio_wr_addr[host_bus_pkg::req_bit];
            cap_idx <= cap_idx + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (desc_region) begin
            reg_addr[cap_idx] <= mmio_wr_data;
            reg_size[cap_idx] <= size_field;
        end
    end

    // Region walk skips unrequested regions
    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n) begin
            walk_state <= walk_idle;
            walk_idx <= '0;
        end else begin
            case (walk_state)
                walk_idle: begin
                    if (wr_base_load) begin
                        walk_idx <= '0;
                        walk_state <= walk_check;
                    end
                end
                walk_check: begin
                    if (reg_req[walk_idx])
                        walk_state <= walk_busy;
                    else if (walk_idx == last_region)
                        walk_state <= walk_idle;
                    else
                        walk_idx <= walk_idx + 1'b1;
                end
                walk_busy: begin
                    if (region_end) begin
                        if (walk_idx == last_region) begin
                            walk_state <= walk_idle;
                        end else begin
                            walk_idx <= walk_idx + 1'b1;
                            walk_state <= walk_check;
                        end
                    end
                end
                default: walk_state <= walk_idle;
            endcase
        end
    end

    assign dma_rd_go = (walk_state == walk_check) && reg_req[walk_idx];
    assign dma_rd_addr = reg_addr[walk_idx];
    assign dma_rd_size = reg_size[walk_idx];
    assign fetch_done = (walk_idx == last_region)
                        && (((walk_state == walk_check) && !reg_req[walk_idx])
                            || ((walk_state == walk_busy) && region_end));

    always_comb begin
        word_we = '0;
        if (word_valid)
            word_we[walk_idx] = 1'b1;
    end

    beat_unloader unloader0 (
        .clk          (clk),
        .rst_n        (rst_n),
        .start        (dma_rd_go),
        .beat_count   (dma_rd_size),
        .dma_rd_empty (dma_rd_empty),
        .dma_rd_data  (dma_rd_data),
        .dma_rd_en    (dma_rd_en),
        .word_data    (word_data),
        .word_valid   (word_valid),
        .region_end   (region_end)
    );

endmodule

/* source/result_writeback.sv */
module result_writeback #(
    parameter int num_thread = 32,
    parameter int patch_count = 2
) (
    input  logic                                                 clk,
    input  logic                                                 rst_n,
    input  logic                                                 patch_done,
    input  logic [batch_pkg::lanes-1:0][batch_pkg::result_w-1:0] result,
    input  logic                                                 dma_wr_full,
    input  logic                                                 dma_wr_done,
    input  logic                                                 wr_base_load,
    input  logic [host_bus_pkg::host_addr_w-1:0]                 wr_base,
    output logic                                                 dma_wr_go,
    output logic                                                 dma_wr_en,
    output logic [host_bus_pkg::host_addr_w-1:0]                 dma_wr_addr,
    output logic [host_bus_pkg::dma_size_w-1:0]                  dma_wr_size,
    output logic [host_bus_pkg::beat_w-1:0]                      dma_wr_data,
    output logic                                                 re_main,
    output logic [batch_pkg::lanes-1:0][batch_pkg::main_addr_w-1:0] main_addr,
    output logic                                                 batch_done,
    output logic                                                 all_done
);

    localparam int batch_beats = num_thread / batch_pkg::lanes;
    localparam int beat_cnt_w = $clog2(batch_beats + 1);
    localparam int patch_cnt_w = $clog2(patch_count + 1);
    localparam int wait_cnt_w = $clog2(batch_pkg::result_wait + 1);
    localparam int tf_w = batch_pkg::thread_field_w;
    localparam logic [beat_cnt_w-1:0] last_beat = beat_cnt_w'(batch_beats);
    localparam logic [patch_cnt_w-1:0] last_patch = patch_cnt_w'(patch_count - 1);
    localparam logic [wait_cnt_w-1:0] wait_done = wait_cnt_w'(batch_pkg::result_wait);
    localparam logic [host_bus_pkg::host_addr_w-1:0] base_step = batch_beats;
    localparam logic [host_bus_pkg::dma_size_w-1:0] batch_size = batch_beats;

    typedef enum logic [1:0] {st_idle, st_load, st_hold, st_done} state_t;

    state_t state, next_state;
    logic [wait_cnt_w-1:0] wait_cnt;
    logic [beat_cnt_w-1:0] beat_cnt;
    logic [patch_cnt_w-1:0] patch_cnt;
    logic [tf_w-1:0] thread_idx;
    logic capture;
    logic base_adv;

    assign dma_wr_size = batch_size;

    // Beat counter already points at the next beat once results are captured
    assign thread_idx = tf_w'(beat_cnt) * tf_w'(batch_pkg::lanes);

    for (genvar k = 0; k < batch_pkg::lanes; k++) begin : g_lane
        assign main_addr[k] = {thread_idx + tf_w'(k), batch_pkg::slot_offset};
    end

    always_comb begin
        next_state = state;
        dma_wr_go = 1'b0;
        dma_wr_en = 1'b0;
        re_main = 1'b0;
        capture = 1'b0;
        base_adv = 1'b0;
        batch_done = 1'b0;
        all_done = 1'b0;
        case (state)
            st_idle: begin
                if (patch_done) begin
                    dma_wr_go = 1'b1;
                    re_main = 1'b1;
                    next_state = st_load;
                end
            end
            st_load: begin
                if (wait_cnt == wait_done) begin
                    capture = 1'b1;
                    next_state = st_hold;
                end
            end
            st_hold: begin
                if (!dma_wr_full) begin
                    dma_wr_en = 1'b1;
                    if (beat_cnt == last_beat) begin
                        base_adv = 1'b1;
                        next_state = st_done;
                    end else begin
                        re_main = 1'b1;
                        next_state = st_load;
                    end
                end
            end
            default: begin
                if (dma_wr_done) begin
                    batch_done = 1'b1;
                    all_done = (patch_cnt == last_patch);
                    next_state = st_idle;
                end
            end
        endcase
    end

    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n) begin
            state <= st_idle;
            wait_cnt <= '0;
            beat_cnt <= '0;
            patch_cnt <= '0;
            dma_wr_addr <= '0;
        end else begin
            state <= next_state;
            if (re_main)
                wait_cnt <= wait_cnt_w'(1);
            else if (state == st_load)
                wait_cnt <= wait_cnt + 1'b1;
            if (base_adv)
                beat_cnt <= '0;
            else if (capture)
                beat_cnt <= beat_cnt + 1'b1;
            if (all_done)
                patch_cnt <= '0;
            else if (batch_done)
                patch_cnt <= patch_cnt + 1'b1;
            if (wr_base_load)
                dma_wr_addr <= wr_base;
            else if (base_adv)
                dma_wr_addr <= dma_wr_addr + base_step;
        end
    end

    // Lane 0 lands in the low bits
    always_ff @(posedge clk) begin
        if (capture)
            dma_wr_data <= result;
    end

endmodule

/* source/host_status.sv */
module host_status (
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  logic                                 mmio_wr_en,
    input  logic                                 ack,
    input  logic                                 fetch_done,
    input  logic                                 batch_done,
    input  logic                                 all_done,
    output logic [host_bus_pkg::mmio_data_w-1:0] mmio_rd_data
);

    localparam int code_w = host_bus_pkg::status_code_w;
    localparam logic [host_bus_pkg::mmio_data_w-1:0] idle_word =
        {{(host_bus_pkg::mmio_data_w - code_w){1'b0}}, host_bus_pkg::status_idle};

    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n) begin
            mmio_rd_data <= idle_word;
        end else if (mmio_wr_en && ack) begin
            // Acknowledge beats any event in the same cycle
            mmio_rd_data <= idle_word;
        end else begin
            if (fetch_done)
                mmio_rd_data[host_bus_pkg::fetch_done_bit] <= 1'b1;
            if (all_done)
                mmio_rd_data[code_w-1:0] <= host_bus_pkg::status_all_done;
            else if (batch_done)
                mmio_rd_data[code_w-1:0] <= host_bus_pkg::status_batch_done;
        end
    end

endmodule

/* source/mem_controller.sv */
module mem_controller #(
    parameter int num_thread = 32,
    parameter int patch_count = 2
) (
    input  logic                                                 clk,
    input  logic                                                 rst_n,
    input  logic                                                 mmio_wr_en,
    input  logic [host_bus_pkg::mmio_addr_w-1:0]                 mmio_wr_addr,
    input  logic [host_bus_pkg::mmio_data_w-1:0]                 mmio_wr_data,
    output logic [host_bus_pkg::mmio_data_w-1:0]                 mmio_rd_data,
    output logic                                                 dma_rd_go,
    output logic                                                 dma_rd_en,
    output logic [host_bus_pkg::host_addr_w-1:0]                 dma_rd_addr,
    output logic [host_bus_pkg::dma_size_w-1:0]                  dma_rd_size,
    input  logic                                                 dma_rd_empty,
    input  logic [host_bus_pkg::beat_w-1:0]                      dma_rd_data,
    output logic [host_bus_pkg::word_w-1:0]                      word_data,
    output logic [host_bus_pkg::region_count-1:0]                word_we,
    output logic                                                 dma_wr_go,
    output logic                                                 dma_wr_en,
    output logic [host_bus_pkg::host_addr_w-1:0]                 dma_wr_addr,
    output logic [host_bus_pkg::dma_size_w-1:0]                  dma_wr_size,
    output logic [host_bus_pkg::beat_w-1:0]                      dma_wr_data,
    input  logic                                                 dma_wr_full,
    input  logic                                                 dma_wr_done,
    input  logic                                                 patch_done,
    output logic                                                 re_main,
    output logic [batch_pkg::lanes-1:0][batch_pkg::main_addr_w-1:0] main_addr,
    input  logic [batch_pkg::lanes-1:0][batch_pkg::result_w-1:0] result
);

    logic wr_base_load;
    logic [host_bus_pkg::host_addr_w-1:0] wr_base;
    logic fetch_done;
    logic batch_done;
    logic all_done;

    // Fetch side
    descriptor_sequencer seq0 (
        .clk          (clk),
        .rst_n        (rst_n),
        .mmio_wr_en   (mmio_wr_en),
        .mmio_wr_addr (mmio_wr_addr),
        .mmio_wr_data (mmio_wr_data),
        .dma_rd_empty (dma_rd_empty),
        .dma_rd_data  (dma_rd_data),
        .dma_rd_go    (dma_rd_go),
        .dma_rd_en    (dma_rd_en),
        .dma_rd_addr  (dma_rd_addr),
        .dma_rd_size  (dma_rd_size),
        .word_data    (word_data),
        .word_we      (word_we),
        .wr_base_load (wr_base_load),
        .wr_base      (wr_base),
        .fetch_done   (fetch_done)
    );

    // Writeback side
    result_writeback #(
        .num_thread  (num_thread),
        .patch_count (patch_count)
    ) wb0 (
        .clk          (clk),
        .rst_n        (rst_n),
        .patch_done   (patch_done),
        .result       (result),
        .dma_wr_full  (dma_wr_full),
        .dma_wr_done  (dma_wr_done),
        .wr_base_load (wr_base_load),
        .wr_base      (wr_base),
        .dma_wr_go    (dma_wr_go),
        .dma_wr_en    (dma_wr_en),
        .dma_wr_addr  (dma_wr_addr),
        .dma_wr_size  (dma_wr_size),
        .dma_wr_data  (dma_wr_data),
        .re_main      (re_main),
        .main_addr    (main_addr),
        .batch_done   (batch_done),
        .all_done     (all_done)
    );

    host_status status0 (
        .clk          (clk),
        .rst_n        (rst_n),
        .mmio_wr_en   (mmio_wr_en),
        .ack          (mmio_wr_addr[host_bus_pkg::ack_bit]),
        .fetch_done   (fetch_done),
        .batch_done   (batch_done),
        .all_done     (all_done),
        .mmio_rd_data (mmio_rd_data)
    );

endmodule

/* verification/clock_gen.sv */
module clock_gen (
    output logic clk,
    output logic rst_n
);
    timeunit 1ns;
    timeprecision 100ps;

    // 4 ns period
    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
    end

endmodule

/* verification/tb_mem_controller.sv */
module tb_mem_controller;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int num_thread = 32;
    localparam int patch_count = 2;
    localparam int regions = host_bus_pkg::region_count;
    localparam int batch_beats = num_thread / batch_pkg::lanes;
    localparam int code_w = host_bus_pkg::status_code_w;
    // Room for stalls on up to 3 beats per region and on every write beat
    localparam int max_cycles = regions * 3 * (host_bus_pkg::words_per_beat + 40)
                                + patch_count * (batch_beats * (batch_pkg::result_wait + 20) + 20)
                                + 1000;

    logic clk;
    logic rst_n;
    logic mmio_wr_en;
    logic [host_bus_pkg::mmio_addr_w-1:0] mmio_wr_addr;
    logic [host_bus_pkg::mmio_data_w-1:0] mmio_wr_data;
    logic [host_bus_pkg::mmio_data_w-1:0] mmio_rd_data;
    logic dma_rd_go;
    logic dma_rd_en;
    logic [host_bus_pkg::host_addr_w-1:0] dma_rd_addr;
    logic [host_bus_pkg::dma_size_w-1:0] dma_rd_size;
    logic dma_rd_empty = 1'b1;
    logic [host_bus_pkg::beat_w-1:0] dma_rd_data = '0;
    logic [host_bus_pkg::word_w-1:0] word_data;
    logic [regions-1:0] word_we;
    logic dma_wr_go;
    logic dma_wr_en;
    logic [host_bus_pkg::host_addr_w-1:0] dma_wr_addr;
    logic [host_bus_pkg::dma_size_w-1:0] dma_wr_size;
    logic [host_bus_pkg::beat_w-1:0] dma_wr_data;
    logic dma_wr_full = 1'b0;
    logic dma_wr_done = 1'b0;
    logic patch_done;
    logic re_main;
    logic [batch_pkg::lanes-1:0][batch_pkg::main_addr_w-1:0] main_addr;
    logic [batch_pkg::lanes-1:0][batch_pkg::result_w-1:0] result = '0;

    integer seed = 32'h87af;
    int errors = 0;
    int words_checked = 0;
    int cycle_cnt = 0;

    // Descriptors and host model state
    logic [host_bus_pkg::host_addr_w-1:0] desc_addr [regions];
    logic [host_bus_pkg::dma_size_w-1:0] desc_size [regions];
    logic [regions-1:0] desc_req;
    logic [host_bus_pkg::host_addr_w-1:0] base;
    logic [31:0] rnd;
    int go_queue [$];
    logic [host_bus_pkg::word_w-1:0] word_queue [$];
    int region_queue [$];
    int beat_count [regions] = '{default: 0};
    int word_count [regions] = '{default: 0};
    int cur_region = 0;
    int exp_beats;
    int exp_r;
    logic [regions-1:0] exp_we;
    logic [host_bus_pkg::word_w-1:0] exp_word;
    logic [host_bus_pkg::beat_w-1:0] beat;

    // Main memory and write channel model state
    logic [batch_pkg::lanes-1:0][batch_pkg::main_addr_w-1:0] pend_addr;
    logic [batch_pkg::lanes-1:0][batch_pkg::result_w-1:0] lanes_next;
    int rd_wait = 0;
    int wr_beats = 0;
    int batch_count = 0;
    int done_wait = 0;
    int beats_written = 0;
    logic [host_bus_pkg::host_addr_w-1:0] exp_wr_base;
    logic [host_bus_pkg::mmio_data_w-1:0] fetch_word;
    logic [host_bus_pkg::mmio_data_w-1:0] exp_status;
    logic [code_w-1:0] exp_code;

    clock_gen clk0 (
        .clk   (clk),
        .rst_n (rst_n)
    );

    mem_controller #(
        .num_thread  (num_thread),
        .patch_count (patch_count)
    ) dut0 (
        .clk          (clk),
        .rst_n        (rst_n),
        .mmio_wr_en   (mmio_wr_en),
        .mmio_wr_addr (mmio_wr_addr),
        .mmio_wr_data (mmio_wr_data),
        .mmio_rd_data (mmio_rd_data),
        .dma_rd_go    (dma_rd_go),
        .dma_rd_en    (dma_rd_en),
        .dma_rd_addr  (dma_rd_addr),
        .dma_rd_size  (dma_rd_size),
        .dma_rd_empty (dma_rd_empty),
        .dma_rd_data  (dma_rd_data),
        .word_data    (word_data),
        .word_we      (word_we),
        .dma_wr_go    (dma_wr_go),
        .dma_wr_en    (dma_wr_en),
        .dma_wr_addr  (dma_wr_addr),
        .dma_wr_size  (dma_wr_size),
        .dma_wr_data  (dma_wr_data),
        .dma_wr_full  (dma_wr_full),
        .dma_wr_done  (dma_wr_done),
        .patch_done   (patch_done),
        .re_main      (re_main),
        .main_addr    (main_addr),
        .result       (result)
    );

    task automatic report_mismatch(input string name, input logic [511:0] exp,
                                   input logic [511:0] act);
        errors++;
        $display("Mismatch %s: expected %0h, actual %0h", name, exp, act);
    endtask

    task automatic report_failure(input string msg);
        errors++;
        $display("Error: %s", msg);
    endtask

    task automatic print_counts();
        $display("Words checked: %0d, write beats checked: %0d, errors: %0d",
                 words_checked, beats_written, errors);
    endtask

    task automatic mmio_write(input logic [31:0] addr, input logic [63:0] data);
        @(posedge clk);
        mmio_wr_en <= 1'b1;
        mmio_wr_addr <= addr;
        mmio_wr_data <= data;
        @(posedge clk);
        mmio_wr_en <= 1'b0;
    endtask

    // Arbitrary but fixed content per main address
    function automatic logic [127:0] lane_value(input logic [31:0] addr);
        return {addr ^ 32'hc3a5_0f1e, ~addr, addr * 32'h9e37_79b1, addr};
    endfunction

    function automatic logic [511:0] expected_beat(input int b);
        logic [511:0] data;
        logic [31:0] addr;
        for (int k = 0; k < batch_pkg::lanes; k++) begin
            addr = {16'(4 * b + k), batch_pkg::slot_offset};
            data[128*k +: 128] = lane_value(addr);
        end
        return data;
    endfunction

    // Host read channel with random empty stalls
    always @(posedge clk) begin
        dma_rd_empty <= (($random(seed) & 3) == 0);
        if (dma_rd_go) begin
            if (go_queue.size() == 0) begin
                report_failure("dma_rd_go pulsed with no requested region left");
            end else begin
                cur_region = go_queue.pop_front();
                assert (dma_rd_addr == desc_addr[cur_region])
                    else report_mismatch("fetch address", 512'(desc_addr[cur_region]),
                                         512'(dma_rd_addr));
                assert (dma_rd_size == desc_size[cur_region])
                    else report_mismatch("fetch size", 512'(desc_size[cur_region]),
                                         512'(dma_rd_size));
            end
        end
        if (dma_rd_en) begin
            assert (!dma_rd_empty) else report_failure("dma_rd_en pulsed while dma_rd_empty high");
            for (int i = 0; i < host_bus_pkg::words_per_beat; i++) begin
                beat[32*i +: 32] = $random(seed);
                word_queue.push_back(beat[32*i +: 32]);
                region_queue.push_back(cur_region);
            end
            dma_rd_data <= beat;
            beat_count[cur_region]++;
        end
        if (word_we != '0) begin
            // Words per region as the DUT enables them
            for (int r = 0; r < regions; r++) begin
                if (word_we[r])
                    word_count[r]++;
            end
            if (word_queue.size() == 0) begin
                report_failure("word_we high with no fetched word pending");
            end else begin
                exp_word = word_queue.pop_front();
                exp_r = region_queue.pop_front();
                exp_we = '0;
                exp_we[exp_r] = 1'b1;
                assert (word_we == exp_we)
                    else report_mismatch("unpack enable", 512'(exp_we), 512'(word_we));
                assert (word_data == exp_word)
                    else report_mismatch("unpack word", 512'(exp_word), 512'(word_data));
                words_checked++;
            end
        end
    end

    // Main memory returns results result_wait cycles after the strobe
    always @(posedge clk) begin
        if (rd_wait == 1) begin
            for (int k = 0; k < batch_pkg::lanes; k++)
                lanes_next[k] = lane_value(pend_addr[k]);
            result <= lanes_next;
        end
        if (rd_wait != 0)
            rd_wait--;
        if (re_main) begin
            pend_addr = main_addr;
            rd_wait = batch_pkg::result_wait - 1;
            result <= '1;
        end
    end

    // Host write channel with random full stalls
    always @(posedge clk) begin
        dma_wr_full <= (($random(seed) & 3) == 0);
        dma_wr_done <= (done_wait == 1);
        if (done_wait != 0)
            done_wait--;
        if (dma_wr_go) begin
            assert (dma_wr_addr == exp_wr_base)
                else report_mismatch("write address", 512'(exp_wr_base), 512'(dma_wr_addr));
            assert (dma_wr_size == host_bus_pkg::dma_size_w'(batch_beats))
                else report_mismatch("write size", 512'(batch_beats), 512'(dma_wr_size));
            wr_beats = 0;
            batch_count++;
        end
        if (dma_wr_en) begin
            assert (!dma_wr_full) else report_failure("dma_wr_en pulsed while dma_wr_full high");
            assert (wr_beats < batch_beats) else report_failure("write beat beyond batch size");
            assert (dma_wr_data == expected_beat(wr_beats))
                else report_mismatch("write data", expected_beat(wr_beats), dma_wr_data);
            wr_beats++;
            beats_written++;
            if (wr_beats == batch_beats) begin
                done_wait = 2 + ($random(seed) & 3);
                exp_wr_base = exp_wr_base + host_bus_pkg::host_addr_w'(batch_beats);
            end
        end
    end

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt >= max_cycles) begin
            report_failure("timeout, the run did not finish within the cycle limit");
            print_counts();
            $display("Done: errors found");
            $finish;
        end
    end

    initial begin
        mmio_wr_en = 1'b0;
        mmio_wr_addr = '0;
        mmio_wr_data = '0;
        patch_done = 1'b0;
        while (!rst_n)
            @(posedge clk);

        // Random descriptors with at least one region requested and one skipped
        for (int r = 0; r < regions; r++) begin
            desc_addr[r] = {$random(seed), $random(seed)};
            rnd = $random(seed);
            desc_size[r] = host_bus_pkg::dma_size_w'(rnd[7:0] % 3 + 1);
            desc_req[r] = rnd[8];
        end
        if (desc_req == '0)
            desc_req[0] = 1'b1;
        if (desc_req == '1)
            desc_req[1] = 1'b0;
        for (int r = 0; r < regions; r++) begin
            if (desc_req[r])
                go_queue.push_back(r);
        end
        for (int r = 0; r < regions; r++)
            mmio_write({desc_req[r], desc_size[r][29:0], 1'b0}, desc_addr[r]);
        base = {$random(seed), $random(seed)};
        exp_wr_base = base;
        mmio_write(32'h0, base);

        while (!mmio_rd_data[host_bus_pkg::fetch_done_bit])
            @(posedge clk);
        fetch_word = '0;
        fetch_word[host_bus_pkg::fetch_done_bit] = 1'b1;
        assert (mmio_rd_data == fetch_word)
            else report_mismatch("status after fetch", 512'(fetch_word), 512'(mmio_rd_data));

        for (int p = 0; p < patch_count; p++) begin
            @(posedge clk);
            patch_done <= 1'b1;
            @(posedge clk);
            patch_done <= 1'b0;
            exp_code = (p == patch_count - 1) ? host_bus_pkg::status_all_done
                                              : host_bus_pkg::status_batch_done;
            while (mmio_rd_data[code_w-1:0] != exp_code)
                @(posedge clk);
            exp_status = fetch_word;
            exp_status[code_w-1:0] = exp_code;
            assert (mmio_rd_data == exp_status)
                else report_mismatch("status after batch", 512'(exp_status), 512'(mmio_rd_data));
            assert (wr_beats == batch_beats)
                else report_mismatch("batch beat count", 512'(batch_beats), 512'(wr_beats));
        end
        assert (batch_count == patch_count)
            else report_mismatch("batch count", 512'(patch_count), 512'(batch_count));

        // Acknowledge clears the whole status word
        mmio_write(32'h1, 64'h0);
        @(posedge clk);
        assert (mmio_rd_data == '0)
            else report_mismatch("status after ack", 512'(0), 512'(mmio_rd_data));

        repeat (10) @(posedge clk);
        for (int r = 0; r < regions; r++) begin
            exp_beats = desc_req[r] ? int'(desc_size[r]) : 0;
            assert (beat_count[r] == exp_beats)
                else report_mismatch("region beat count", 512'(exp_beats), 512'(beat_count[r]));
            assert (word_count[r] == exp_beats * host_bus_pkg::words_per_beat)
                else report_mismatch("region word count",
                                     512'(exp_beats * host_bus_pkg::words_per_beat),
                                     512'(word_count[r]));
        end
        assert (go_queue.size() == 0) else report_failure("a requested region was never fetched");
        assert (word_queue.size() == 0) else report_failure("fetched words never reached word_we");

        print_counts();
        if (errors == 0)
            $display("Done: no errors");
        else
            $display("Done: errors found");
        $finish;
    end

endmodule

/* mem_controller.f */
source/host_bus_pkg.sv
source/batch_pkg.sv
source/beat_unloader.sv
source/descriptor_sequencer.sv
source/result_writeback.sv
source/host_status.sv
source/mem_controller.sv
verification/clock_gen.sv
verification/tb_mem_controller.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the testbench with Verilator, then judge the log
set -o pipefail
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_mem_controller \
    -f mem_controller.f -Mdir obj_dir -o sim_tb \
    && ./obj_dir/sim_tb 2>&1 | tee sim.log \
    || { echo "Build or simulation run failed"; exit 1; }
grep -q "Done: errors found" sim.log \
    && { echo "Simulation FAILED"; exit 1; } \
    || { echo "Simulation passed"; exit 0; }
